// ==== proc_decode.sv ====
module proc_decode import proc_pkg::*; (
    input  word_t    i_instr,
    input  word_t    i_instr_pc,
    output decoded_t o_dec,
    output word_t    o_dec_pc
);

    instr_t ins;
    word_t  imm_ext;

    assign ins = instr_t'(i_instr);

    // sign extend the 19-bit field to a full word
    assign imm_ext = {{13{ins.imm[18]}}, ins.imm};

    always_comb begin
        o_dec     = '0;
        o_dec.rd  = ins.rd;
        o_dec.ra  = ins.ra;
        o_dec.imm = imm_ext;
        case (ins.op)
            OP_ADDI: begin
                o_dec.op     = OP_ADDI;
                o_dec.wr_reg = 1'b1;
            end
            OP_LD: begin
                o_dec.op     = OP_LD;
                o_dec.wr_reg = 1'b1;
                o_dec.mem_rd = 1'b1;
            end
            OP_ST: begin
                o_dec.op     = OP_ST;
                o_dec.mem_wr = 1'b1;
            end
            OP_BRX: begin
                o_dec.op = OP_BRX;
            end
            OP_JFR: begin
                o_dec.op = OP_JFR;
            end
            default: begin
                // unknown opcodes fall back to a no-op
                o_dec.op = OP_NOP;
            end
        endcase
    end

    assign o_dec_pc = i_instr_pc;

endmodule

// ==== proc_execute.sv ====
module proc_execute import proc_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    input  decoded_t i_dec,
    input  word_t    i_pc,
    input  word_t    i_ra_data,
    input  word_t    i_rd_data,
    input  logic     i_stall,
    output logic     o_exec_valid,
    output exec_t    o_exec,
    output logic     o_redirect,
    output word_t    o_redirect_pc
);

    br_cond_t cond;
    word_t    sum;
    word_t    br_target;
    logic     br_taken;
    exec_t    nxt;

    // branches keep their condition in the ra slot
    assign cond = br_cond_t'(i_dec.ra);

    // shared adder for addi result and load/store address
    assign sum = i_ra_data + i_dec.imm;

    // own address plus one plus four times the offset
    assign br_target = i_pc + 32'd1 + (i_dec.imm << 2);

    always_comb begin
        case (cond)
            BR_ZERO: br_taken = (i_rd_data == '0);
            BR_NZRO: br_taken = (i_rd_data != '0);
            BR_POSI: br_taken = !i_rd_data[31];
            BR_NEGA: br_taken = i_rd_data[31];
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        nxt          = '0;
        nxt.result   = sum;
        nxt.addr     = sum;
        nxt.st_data  = i_rd_data;
        nxt.rd       = i_dec.rd;
        nxt.wr_reg   = i_dec.wr_reg;
        nxt.mem_rd   = i_dec.mem_rd;
        nxt.mem_wr   = i_dec.mem_wr;
        case (i_dec.op)
            OP_BRX: begin
                nxt.redirect = br_taken;
                nxt.target   = br_target;
            end
            OP_JFR: begin
                nxt.redirect = 1'b1;
                nxt.target   = i_rd_data;
            end
            default: ;
        endcase
    end

    // hold everything while the memory stage owns the port
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_exec_valid <= 1'b0;
        end
        else if (!i_stall) begin
            o_exec_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall && i_valid) begin
            o_exec <= nxt;
        end
    end

    // one-cycle pulse alongside the registered result
    assign o_redirect    = o_exec_valid && o_exec.redirect;
    assign o_redirect_pc = o_exec.target;

endmodule

// ==== proc_fetch.sv ====
module proc_fetch import proc_pkg::*; #(
    parameter word_t P_START_PC = 32'd0
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    output logic  o_fetch_req,
    output word_t o_fetch_addr,
    input  logic  i_fetch_done,
    input  word_t i_fetch_word,
    input  logic  i_redirect,
    input  word_t i_redirect_pc,
    input  logic  i_stall,
    output logic  o_instr_valid,
    output word_t o_instr,
    output word_t o_instr_pc
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } fetch_state_t;

    fetch_state_t state;
    word_t        pc;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
            pc    <= P_START_PC;
        end
        else begin
            case (state)
                S_IDLE: state <= S_REQ;
                // data access owns the port, wait until it is released
                S_REQ:  if (i_stall) state <= S_WAIT;
                S_WAIT: if (!i_stall) state <= S_REQ;
                default: state <= S_IDLE;
            endcase
            // redirect overrides the sequential advance
            if (i_redirect) begin
                pc <= i_redirect_pc;
            end
            else if (i_fetch_done) begin
                pc <= pc + 32'd1;
            end
        end
    end

    // no request on the wrong path while a redirect is pending
    assign o_fetch_req  = (state == S_REQ) && !i_redirect;
    assign o_fetch_addr = pc;

    // word is handed on in the cycle it arrives, dropped on a redirect
    assign o_instr_valid = i_fetch_done && !i_redirect;
    assign o_instr       = i_fetch_word;
    assign o_instr_pc    = pc;

endmodule

// ==== proc_mem_stage.sv ====
module proc_mem_stage import proc_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_exec_valid,
    input  exec_t    i_exec,
    input  logic     i_fetch_req,
    input  word_t    i_fetch_addr,
    output logic     o_fetch_done,
    output word_t    o_fetch_word,
    output logic     o_stall,
    output logic     o_wr_en,
    output reg_idx_t o_wr_idx,
    output word_t    o_wr_data,
    output word_t    o_mem_addr,
    output word_t    o_mem_wdata,
    input  word_t    i_mem_rdata,
    output logic     o_mem_read,
    output logic     o_mem_write,
    input  logic     i_mem_rdy
);

    logic     port_busy;
    logic     acc_done;
    logic     start_data;
    logic     start_fetch;
    logic     ld_done;
    logic     data_acc;
    reg_idx_t ld_idx;

    assign port_busy = o_mem_read || o_mem_write;
    assign acc_done  = port_busy && i_mem_rdy;

    // data access wins the port over instruction fetch
    assign start_data  = !port_busy && i_exec_valid && (i_exec.mem_rd || i_exec.mem_wr);
    assign start_fetch = !port_busy && !start_data && i_fetch_req;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            data_acc    <= 1'b0;
        end
        else if (acc_done) begin
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            data_acc    <= 1'b0;
        end
        else if (start_data) begin
            o_mem_read  <= i_exec.mem_rd;
            o_mem_write <= i_exec.mem_wr;
            data_acc    <= 1'b1;
        end
        else if (start_fetch) begin
            o_mem_read <= 1'b1;
        end
    end

    // address and data stay put until ready
    always_ff @(posedge i_clk) begin
        if (start_data) begin
            o_mem_addr  <= i_exec.addr;
            o_mem_wdata <= i_exec.st_data;
            ld_idx      <= i_exec.rd;
        end
        else if (start_fetch) begin
            o_mem_addr <= i_fetch_addr;
        end
    end

    assign o_fetch_done = acc_done && !data_acc;
    assign o_fetch_word = i_mem_rdata;
    assign o_stall      = data_acc;

    // load data lands on completion, alu results the cycle after execute
    assign ld_done   = acc_done && data_acc && o_mem_read;
    assign o_wr_en   = ld_done || (i_exec_valid && i_exec.wr_reg && !i_exec.mem_rd);
    assign o_wr_idx  = ld_done ? ld_idx : i_exec.rd;
    assign o_wr_data = ld_done ? i_mem_rdata : i_exec.result;

endmodule

// ==== proc_pkg.sv ====
package proc_pkg;

    // data and address word, program counter counts words
    typedef logic [31:0] word_t;

    // register index, r0 reads as zero
    typedef logic [3:0] reg_idx_t;

    // raw immediate field of an instruction
    typedef logic [18:0] imm_t;

    typedef enum logic [4:0] {
        OP_NOP  = 5'h00,
        OP_ADDI = 5'h01,
        OP_LD   = 5'h02,
        OP_ST   = 5'h03,
        OP_BRX  = 5'h04,
        OP_JFR  = 5'h05
    } opcode_t;

    // branch condition, carried in the ra slot of a branch
    typedef enum logic [3:0] {
        BR_ZERO = 4'h0,
        BR_NZRO = 4'h1,
        BR_POSI = 4'h2,
        BR_NEGA = 4'h3
    } br_cond_t;

    // instruction word layout, msb first
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t ra;
        imm_t     imm;
    } instr_t;

    // decoder output
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t ra;
        word_t    imm;
        logic     wr_reg;
        logic     mem_rd;
        logic     mem_wr;
    } decoded_t;

    // execute result handed to the memory stage
    typedef struct packed {
        word_t    result;
        word_t    addr;
        word_t    st_data;
        reg_idx_t rd;
        logic     wr_reg;
        logic     mem_rd;
        logic     mem_wr;
        logic     redirect;
        word_t    target;
    } exec_t;

endpackage

// ==== proc_regfile.sv ====
module proc_regfile import proc_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  reg_idx_t i_ra,
    input  reg_idx_t i_rb,
    output word_t    o_ra_data,
    output word_t    o_rb_data,
    input  logic     i_wr_en,
    input  reg_idx_t i_wr_idx,
    input  word_t    i_wr_data
);

    word_t regs [16];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end
        // r0 is never written, so it stays zero
        else if (i_wr_en && (i_wr_idx != '0)) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    assign o_ra_data = regs[i_ra];
    assign o_rb_data = regs[i_rb];

endmodule

// ==== proc_top.sv ====
module proc_top import proc_pkg::*; #(
    parameter word_t P_START_PC = 32'd0
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    output word_t o_mem_addr,
    output word_t o_mem_wdata,
    input  word_t i_mem_rdata,
    output logic  o_mem_read,
    output logic  o_mem_write,
    input  logic  i_mem_rdy
);

    // fetch <-> memory stage
    logic     fetch_req;
    word_t    fetch_addr;
    logic     fetch_done;
    word_t    fetch_word;
    logic     stall;

    // fetch -> decode -> execute
    logic     instr_valid;
    word_t    instr;
    word_t    instr_pc;
    decoded_t dec;
    word_t    dec_pc;

    // register file reads and writeback
    word_t    ra_data;
    word_t    rd_data;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    // execute outputs
    logic     exec_valid;
    exec_t    exec_q;
    logic     redirect;
    word_t    redirect_pc;

    proc_fetch #(
        .P_START_PC(P_START_PC)
    ) u_fetch (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_fetch_req  (fetch_req),
        .o_fetch_addr (fetch_addr),
        .i_fetch_done (fetch_done),
        .i_fetch_word (fetch_word),
        .i_redirect   (redirect),
        .i_redirect_pc(redirect_pc),
        .i_stall      (stall),
        .o_instr_valid(instr_valid),
        .o_instr      (instr),
        .o_instr_pc   (instr_pc)
    );

    proc_decode u_decode (
        .i_instr   (instr),
        .i_instr_pc(instr_pc),
        .o_dec     (dec),
        .o_dec_pc  (dec_pc)
    );

    // port b reads rd, the branch test value and store data
    proc_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ra     (dec.ra),
        .i_rb     (dec.rd),
        .o_ra_data(ra_data),
        .o_rb_data(rd_data),
        .i_wr_en  (wr_en),
        .i_wr_idx (wr_idx),
        .i_wr_data(wr_data)
    );

    proc_execute u_execute (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (instr_valid),
        .i_dec        (dec),
        .i_pc         (dec_pc),
        .i_ra_data    (ra_data),
        .i_rd_data    (rd_data),
        .i_stall      (stall),
        .o_exec_valid (exec_valid),
        .o_exec       (exec_q),
        .o_redirect   (redirect),
        .o_redirect_pc(redirect_pc)
    );

    proc_mem_stage u_mem_stage (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_exec_valid(exec_valid),
        .i_exec      (exec_q),
        .i_fetch_req (fetch_req),
        .i_fetch_addr(fetch_addr),
        .o_fetch_done(fetch_done),
        .o_fetch_word(fetch_word),
        .o_stall     (stall),
        .o_wr_en     (wr_en),
        .o_wr_idx    (wr_idx),
        .o_wr_data   (wr_data),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_read  (o_mem_read),
        .o_mem_write (o_mem_write),
        .i_mem_rdy   (i_mem_rdy)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the processor testbench with Verilator and runs it
# exit status is nonzero when the build or the simulation fails

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not installed or not on PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f --top-module tb_proc -o Vtb_proc
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build returned status $status"
    exit "$status"
fi

./obj_dir/Vtb_proc
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation run returned status $status"
    exit "$status"
fi

exit 0

// ==== sim.f ====
proc_pkg.sv
proc_fetch.sv
proc_decode.sv
proc_regfile.sv
proc_execute.sv
proc_mem_stage.sv
proc_top.sv
tb_proc_mem.sv
tb_proc.sv

// ==== tb_proc.sv ====
module tb_proc import proc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int       MEM_WORDS     = 256;
    localparam int       AW            = $clog2(MEM_WORDS);
    localparam word_t    START_PC      = 32'h0000_0000;
    localparam int       STORE_TIMEOUT = 200;
    localparam int       REF_STEPS     = 2000;
    localparam int       POISON        = 'hBAD;
    localparam reg_idx_t R0            = 4'd0;
    localparam reg_idx_t R1            = 4'd1;
    localparam reg_idx_t R2            = 4'd2;
    localparam reg_idx_t R3            = 4'd3;
    localparam reg_idx_t R5            = 4'd5;

    logic  clk;
    logic  rst_n;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_read;
    logic  mem_write;
    logic  mem_rdy;

    word_t          image [MEM_WORDS];
    logic  [AW-1:0] load_ptr;
    word_t          exp_addr [$];
    word_t          exp_data [$];
    int             n_checked = 0;

    // state of an access still waiting for ready
    logic  held = 1'b0;
    logic  held_read;
    logic  held_write;
    word_t held_addr;
    word_t held_wdata;

    proc_top #(
        .P_START_PC(START_PC)
    ) dut0 (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .o_mem_addr (mem_addr),
        .o_mem_wdata(mem_wdata),
        .i_mem_rdata(mem_rdata),
        .o_mem_read (mem_read),
        .o_mem_write(mem_write),
        .i_mem_rdy  (mem_rdy)
    );

    tb_proc_mem #(
        .P_WORDS(MEM_WORDS)
    ) mem0 (
        .i_clk  (clk),
        .i_rst_n(rst_n),
        .i_image(image),
        .i_addr (mem_addr),
        .i_wdata(mem_wdata),
        .o_rdata(mem_rdata),
        .i_read (mem_read),
        .i_write(mem_write),
        .o_rdy  (mem_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // opcode, rd, ra, 19-bit immediate
    function automatic word_t encode(input opcode_t op, input reg_idx_t rd,
                                     input reg_idx_t ra, input int imm);
        return {op, rd, ra, imm[18:0]};
    endfunction

    function automatic void emit(input word_t w);
        image[load_ptr] = w;
        load_ptr = load_ptr + 1'b1;
    endfunction

    // branches always test r1
    function automatic void emit_branch(input br_cond_t cond, input int offset);
        emit(encode(OP_BRX, R1, reg_idx_t'(cond), offset));
    endfunction

    function automatic void emit_poison(input int words);
        for (int i = 0; i < words; i++) begin
            emit(encode(OP_ADDI, R1, R0, POISON));
        end
    endfunction

    function automatic void build_program();
        // filler decodes as a no-op whose immediate is its own address
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = word_t'(i);
        end
        load_ptr = START_PC[AW-1:0];
        emit(encode(OP_ADDI, R2, R0, 'h80));
        emit(encode(OP_ADDI, R1, R0, 5));
        emit(encode(OP_ST, R1, R2, 0));
        emit(encode(OP_ADDI, R1, R1, -12));
        emit(encode(OP_ST, R1, R2, 1));
        // zero test falls through on -7 and is taken on 0
        emit_branch(BR_ZERO, 1);
        emit(encode(OP_ADDI, R1, R0, 'h11));
        emit(encode(OP_ST, R1, R2, 2));
        emit(encode(OP_ADDI, R1, R0, 0));
        emit_branch(BR_ZERO, 1);
        emit_poison(4);
        emit(encode(OP_ST, R1, R2, 3));
        // nonzero test falls through on 0 and is taken on 0x22
        emit_branch(BR_NZRO, 1);
        emit(encode(OP_ADDI, R1, R0, 'h22));
        emit(encode(OP_ST, R1, R2, 4));
        emit_branch(BR_NZRO, 1);
        emit_poison(4);
        emit(encode(OP_ST, R1, R2, 5));
        // plus test falls through on -3 and is taken on 0x33
        emit(encode(OP_ADDI, R1, R0, -3));
        emit_branch(BR_POSI, 1);
        emit(encode(OP_ADDI, R1, R0, 'h33));
        emit(encode(OP_ST, R1, R2, 6));
        emit_branch(BR_POSI, 1);
        emit_poison(4);
        emit(encode(OP_ST, R1, R2, 7));
        // minus test falls through on 0x33 and takes a longer hop on -0x44
        emit_branch(BR_NEGA, 1);
        emit(encode(OP_ADDI, R1, R0, -'h44));
        emit(encode(OP_ST, R1, R2, 8));
        emit_branch(BR_NEGA, 2);
        emit_poison(8);
        emit(encode(OP_ST, R1, R2, 9));
        // load back a stored word and store it below the base
        emit(encode(OP_ADDI, R1, R0, 'h1234));
        emit(encode(OP_ST, R1, R2, 10));
        emit(encode(OP_LD, R3, R2, 10));
        emit(encode(OP_ST, R3, R2, -1));
        emit(encode(OP_ADDI, R5, R0, int'(START_PC)));
        emit(encode(OP_JFR, R5, R0, 0));
    endfunction

    // instruction-level model collecting two passes of stores
    function automatic bit compute_expected();
        word_t       regs [16];
        word_t       dmem [MEM_WORDS];
        word_t       pc;
        word_t       nxt;
        word_t       imm;
        word_t       addr;
        logic [31:0] ins;
        opcode_t     op;
        reg_idx_t    rd;
        reg_idx_t    ra;
        bit          taken;
        int          starts;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = image[i];
        end
        exp_addr.delete();
        exp_data.delete();
        pc     = START_PC;
        starts = 0;
        for (int step = 0; step < REF_STEPS; step++) begin
            if (pc == START_PC) begin
                starts++;
                if (starts == 3) begin
                    return 1'b1;
                end
            end
            ins  = dmem[pc[AW-1:0]];
            op   = opcode_t'(ins[31:27]);
            rd   = ins[26:23];
            ra   = ins[22:19];
            imm  = {{13{ins[18]}}, ins[18:0]};
            addr = regs[ra] + imm;
            nxt  = pc + 32'd1;
            case (op)
                OP_ADDI: regs[rd] = addr;
                OP_LD:   regs[rd] = dmem[addr[AW-1:0]];
                OP_ST: begin
                    dmem[addr[AW-1:0]] = regs[rd];
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[rd]);
                end
                OP_BRX: begin
                    case (br_cond_t'(ra))
                        BR_ZERO: taken = (regs[rd] == 32'd0);
                        BR_NZRO: taken = (regs[rd] != 32'd0);
                        BR_POSI: taken = (regs[rd][31] == 1'b0);
                        BR_NEGA: taken = (regs[rd][31] == 1'b1);
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        nxt = pc + 32'd1 + imm * 32'd4;
                    end
                end
                OP_JFR:  nxt = regs[rd];
                default: ;
            endcase
            regs[0] = '0;
            pc      = nxt;
        end
        return 1'b0;
    endfunction

    // port hold rules and completed stores against the reference
    always @(posedge clk) begin
        if (rst_n) begin
            check_value("o_mem_read & o_mem_write", {31'd0, mem_read & mem_write}, 32'd0);
            if (held) begin
                check_value("o_mem_addr", mem_addr, held_addr);
                check_value("o_mem_read", {31'd0, mem_read}, {31'd0, held_read});
                check_value("o_mem_write", {31'd0, mem_write}, {31'd0, held_write});
                if (held_write) begin
                    check_value("o_mem_wdata", mem_wdata, held_wdata);
                end
            end
            held       = (mem_read || mem_write) && !mem_rdy;
            held_read  = mem_read;
            held_write = mem_write;
            held_addr  = mem_addr;
            held_wdata = mem_wdata;
            if (mem_write && mem_rdy) begin
                if (n_checked >= exp_addr.size()) begin
                    $display("store to 0x%08h came after all %0d expected stores",
                             mem_addr, exp_addr.size());
                    $display("sim failed");
                    $fatal(1, "unexpected store");
                end
                else begin
                    check_value("o_mem_addr", mem_addr, exp_addr[n_checked]);
                    check_value("o_mem_wdata", mem_wdata, exp_data[n_checked]);
                    n_checked++;
                end
            end
        end
    end

    initial begin
        int wait_cycles;
        int n_expected;
        rst_n = 1'b0;
        build_program();
        if (!compute_expected()) begin
            $display("reference model never completed two passes of the program");
            $display("sim failed");
            $fatal(1, "reference model");
        end
        n_expected = exp_addr.size();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_expected; i++) begin
            wait_cycles = 0;
            while (n_checked <= i && wait_cycles < STORE_TIMEOUT) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (n_checked <= i) begin
                $display("timeout: store %0d of %0d did not complete within %0d cycles",
                         i + 1, n_expected, STORE_TIMEOUT);
                $display("sim failed");
                $fatal(1, "timeout");
            end
        end
        @(negedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== tb_proc_mem.sv ====
module tb_proc_mem import proc_pkg::*; #(
    parameter int P_WORDS = 256
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  word_t i_image [P_WORDS],
    input  word_t i_addr,
    input  word_t i_wdata,
    output word_t o_rdata,
    input  logic  i_read,
    input  logic  i_write,
    output logic  o_rdy
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = $clog2(P_WORDS);

    word_t  mem [P_WORDS];
    integer seed;
    int     wait_left;
    logic   pending;

    initial begin
        seed      = 97297;
        wait_left = 0;
        pending   = 1'b0;
        o_rdy     = 1'b0;
        o_rdata   = '0;
    end

    // image is reloaded while reset is held, stores land on the completing edge
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < P_WORDS; i++) begin
                mem[i] <= i_image[i];
            end
        end
        else if (i_write && o_rdy) begin
            mem[i_addr[AW-1:0]] <= i_wdata;
        end
    end

    // ready after 0 to 3 extra cycles, driven on the falling edge
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            o_rdy   <= 1'b0;
            pending = 1'b0;
        end
        else if (o_rdy) begin
            // access finished on the last rising edge
            o_rdy   <= 1'b0;
            pending = 1'b0;
        end
        else if (i_read || i_write) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                o_rdy   <= 1'b1;
                o_rdata <= mem[i_addr[AW-1:0]];
            end
            else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule
